// ==== include/clk_rst_cfg.svh ====
`ifndef CLK_RST_CFG_SVH
`define CLK_RST_CFG_SVH

// Reset hold lasts 2**RST_CNT_W cycles of sys_clk0
`define RST_CNT_W   8

// User clock domains fed from the system reset
`define NUM_DOMAINS 3

`define SYNC_STAGES 4   // Flops per domain reset chain

// AXI4-Lite register bus
`define AXIL_ADDR_W 4
`define AXIL_DATA_W 32
`define AXIL_STRB_W (`AXIL_DATA_W / 8)

`endif

// ==== rtl/rst_seq_pkg.sv ====
`include "clk_rst_cfg.svh"

package rst_seq_pkg;

  localparam int LOSS_CNT_W = 16;

  typedef logic [`RST_CNT_W-1:0]   rst_cnt_t;    // Hold counter
  typedef logic [LOSS_CNT_W-1:0]   loss_cnt_t;   // Saturating lock-loss count
  typedef logic [`NUM_DOMAINS-1:0] domain_vec_t; // One bit per user domain

  // Sequencer states
  typedef enum logic [1:0] {
    wait_lock = 2'd0,
    hold      = 2'd1,
    run       = 2'd2
  } seq_state_t;

endpackage

// ==== rtl/axil_regs_pkg.sv ====
`include "clk_rst_cfg.svh"

package axil_regs_pkg;

  typedef logic [`AXIL_ADDR_W-1:0] axil_addr_t;
  typedef logic [`AXIL_DATA_W-1:0] axil_data_t;
  typedef logic [`AXIL_STRB_W-1:0] axil_strb_t;
  typedef logic [1:0]              axil_resp_t;

  localparam axil_resp_t RESP_OKAY   = 2'b00;
  localparam axil_resp_t RESP_SLVERR = 2'b10;

  // Register map
  localparam axil_addr_t REG_STATUS   = 'h0; // Read-only live status
  localparam axil_addr_t REG_LOSS_CNT = 'h4; // Read-only lock-loss count
  localparam axil_addr_t REG_CONTROL  = 'h8; // Write-only, reads as zero

  // Status word layout
  localparam int STATUS_LOCK_BIT  = 0;
  localparam int STATUS_RST_BIT   = 1;
  localparam int STATUS_READY_LSB = 4;

  localparam int CTRL_SOFT_RST_BIT = 0;

endpackage

// ==== rtl/reset_sequencer.sv ====
`timescale 1ns/1ps

module reset_sequencer (
  input  logic                   sys_clk0,
  input  logic                   reset,
  input  logic                   pll_lock,
  input  logic                   soft_rst,
  output logic                   sys_rst,
  output rst_seq_pkg::loss_cnt_t loss_cnt
);
  import rst_seq_pkg::*;

  seq_state_t state;
  rst_cnt_t   hold_cnt;

  // Hold the reset until lock has been stable for a full counter period
  always_ff @(posedge sys_clk0) begin
    if (reset || soft_rst) begin
      state    <= wait_lock;
      hold_cnt <= '0;
    end else begin
      case (state)
        wait_lock: begin
          hold_cnt <= '0;
          if (pll_lock) state <= hold;
        end
        hold: begin
          if (!pll_lock) begin
            state <= wait_lock;  // Lost lock mid hold
          end else if (hold_cnt == '1) begin
            state <= run;
          end else begin
            hold_cnt <= hold_cnt + 1'b1;
          end
        end
        run: begin
          if (!pll_lock) state <= wait_lock;
        end
        default: state <= wait_lock;
      endcase
    end
  end

  // Extra output register, as on the board design.
  // Lock loss and soft reset assert it without waiting for the state change.
  always_ff @(posedge sys_clk0) begin
    if (reset) begin
      sys_rst <= 1'b1;
    end else begin
      sys_rst <= (state != run) || !pll_lock || soft_rst;
    end
  end

  // Lock losses once the hold has begun, saturating
  always_ff @(posedge sys_clk0) begin
    if (reset) begin
      loss_cnt <= '0;
    end else if ((state != wait_lock) && !pll_lock && (loss_cnt != '1)) begin
      loss_cnt <= loss_cnt + 1'b1;
    end
  end

endmodule

// ==== rtl/domain_rst_sync.sv ====
`timescale 1ns/1ps
`include "clk_rst_cfg.svh"

module domain_rst_sync (
  input  logic sys_clk0,
  input  logic user_clk,
  input  logic sys_rst,
  output logic domain_rst,
  output logic domain_ready
);

  // Chain powers up asserted so the domain starts in reset
  (* async_reg = "true" *) logic [`SYNC_STAGES-1:0] rst_chain = '1;

  // Release status back into sys_clk0
  (* async_reg = "true" *) logic [1:0] ready_sync = '0;

  always_ff @(posedge user_clk) begin
    rst_chain <= {rst_chain[`SYNC_STAGES-2:0], sys_rst};
  end

  assign domain_rst = rst_chain[`SYNC_STAGES-1];

  // Ready only once the last stage has actually let go
  always_ff @(posedge sys_clk0) begin
    ready_sync <= {ready_sync[0], ~rst_chain[`SYNC_STAGES-1]};
  end

  assign domain_ready = ready_sync[1];

endmodule

// ==== rtl/reset_status_regs.sv ====
`timescale 1ns/1ps
`include "clk_rst_cfg.svh"

module reset_status_regs (
  input  logic                      sys_clk0,
  input  logic                      reset,
  input  logic                      pll_lock,
  input  logic                      sys_rst,
  input  rst_seq_pkg::domain_vec_t  domain_ready,
  input  rst_seq_pkg::loss_cnt_t    loss_cnt,
  output logic                      soft_rst,
  input  axil_regs_pkg::axil_addr_t awaddr,
  input  logic                      awvalid,
  output logic                      awready,
  input  axil_regs_pkg::axil_data_t wdata,
  input  axil_regs_pkg::axil_strb_t wstrb,
  input  logic                      wvalid,
  output logic                      wready,
  output axil_regs_pkg::axil_resp_t bresp,
  output logic                      bvalid,
  input  logic                      bready,
  input  axil_regs_pkg::axil_addr_t araddr,
  input  logic                      arvalid,
  output logic                      arready,
  output axil_regs_pkg::axil_data_t rdata,
  output axil_regs_pkg::axil_resp_t rresp,
  output logic                      rvalid,
  input  logic                      rready
);
  import axil_regs_pkg::*;

  logic       wr_ready;
  logic       wr_accept;
  logic       rd_accept;
  axil_resp_t wr_resp;
  axil_resp_t rd_resp;
  axil_data_t rd_value;
  axil_data_t status_word;

  // Address and data channels are taken in the same cycle
  assign awready   = wr_ready;
  assign wready    = wr_ready;
  assign wr_accept = wr_ready && awvalid && wvalid;
  assign rd_accept = arready && arvalid;

  always_ff @(posedge sys_clk0) begin
    if (reset) begin
      wr_ready <= 1'b0;
      bvalid   <= 1'b0;
    end else begin
      wr_ready <= awvalid && wvalid && !wr_ready && !bvalid;  // One-cycle pulse
      if (wr_accept) begin
        bvalid <= 1'b1;
      end else if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge sys_clk0) begin
    if (reset) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      arready <= arvalid && !arready && !rvalid;  // Blocked while a response is held
      if (rd_accept) begin
        rvalid <= 1'b1;
      end else if (rvalid && rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  // Only the control register takes writes
  assign wr_resp = (awaddr == REG_CONTROL) ? RESP_OKAY : RESP_SLVERR;

  assign soft_rst = wr_accept && (awaddr == REG_CONTROL) &&
                    wstrb[0] && wdata[CTRL_SOFT_RST_BIT];

  always_comb begin
    status_word = '0;
    status_word[STATUS_LOCK_BIT] = pll_lock;
    status_word[STATUS_RST_BIT]  = sys_rst;
    status_word[STATUS_READY_LSB +: `NUM_DOMAINS] = domain_ready;
  end

  // Read decode
  always_comb begin
    rd_value = '0;
    rd_resp  = RESP_OKAY;
    case (araddr)
      REG_STATUS:   rd_value = status_word;
      REG_LOSS_CNT: rd_value = axil_data_t'(loss_cnt);
      REG_CONTROL:  rd_value = '0;  // Write-only
      default:      rd_resp  = RESP_SLVERR;
    endcase
  end

  // Response payload, held until the master takes it
  always_ff @(posedge sys_clk0) begin
    if (wr_accept) bresp <= wr_resp;
    if (rd_accept) begin
      rdata <= rd_value;
      rresp <= rd_resp;
    end
  end

endmodule

// ==== rtl/clk_rst_infra.sv ====
`timescale 1ns/1ps
`include "clk_rst_cfg.svh"

module clk_rst_infra (
  input  logic                      sys_clk0,
  input  logic                      reset,
  input  logic                      pll_lock,
  input  rst_seq_pkg::domain_vec_t  user_clk,
  output logic                      sys_rst,
  output rst_seq_pkg::domain_vec_t  domain_rst,
  input  axil_regs_pkg::axil_addr_t awaddr,
  input  logic                      awvalid,
  output logic                      awready,
  input  axil_regs_pkg::axil_data_t wdata,
  input  axil_regs_pkg::axil_strb_t wstrb,
  input  logic                      wvalid,
  output logic                      wready,
  output axil_regs_pkg::axil_resp_t bresp,
  output logic                      bvalid,
  input  logic                      bready,
  input  axil_regs_pkg::axil_addr_t araddr,
  input  logic                      arvalid,
  output logic                      arready,
  output axil_regs_pkg::axil_data_t rdata,
  output axil_regs_pkg::axil_resp_t rresp,
  output logic                      rvalid,
  input  logic                      rready
);
  import rst_seq_pkg::*;

  logic        soft_rst;
  loss_cnt_t   loss_cnt;
  domain_vec_t domain_ready;

  reset_sequencer u_seq (
    .sys_clk0 (sys_clk0),
    .reset    (reset),
    .pll_lock (pll_lock),
    .soft_rst (soft_rst),
    .sys_rst  (sys_rst),
    .loss_cnt (loss_cnt)
  );

  // One synchronizer per user clock domain
  for (genvar i = 0; i < `NUM_DOMAINS; i++) begin : g_domain
    domain_rst_sync u_sync (
      .sys_clk0     (sys_clk0),
      .user_clk     (user_clk[i]),
      .sys_rst      (sys_rst),
      .domain_rst   (domain_rst[i]),
      .domain_ready (domain_ready[i])
    );
  end

  reset_status_regs u_regs (
    .sys_clk0     (sys_clk0),
    .reset        (reset),
    .pll_lock     (pll_lock),
    .sys_rst      (sys_rst),
    .domain_ready (domain_ready),
    .loss_cnt     (loss_cnt),
    .soft_rst     (soft_rst),
    .awaddr       (awaddr),
    .awvalid      (awvalid),
    .awready      (awready),
    .wdata        (wdata),
    .wstrb        (wstrb),
    .wvalid       (wvalid),
    .wready       (wready),
    .bresp        (bresp),
    .bvalid       (bvalid),
    .bready       (bready),
    .araddr       (araddr),
    .arvalid      (arvalid),
    .arready      (arready),
    .rdata        (rdata),
    .rresp        (rresp),
    .rvalid       (rvalid),
    .rready       (rready)
  );

endmodule

// ==== dv/clk_rst_infra_asserts.sv ====
`timescale 1ns/1ps
`include "clk_rst_cfg.svh"

module clk_rst_infra_asserts (
  input logic                      sys_clk0,
  input logic                      reset,
  input logic                      pll_lock,
  input rst_seq_pkg::domain_vec_t  user_clk,
  input logic                      sys_rst,
  input rst_seq_pkg::domain_vec_t  domain_rst,
  input logic                      soft_rst,
  input rst_seq_pkg::seq_state_t   seq_state,
  input logic                      awvalid,
  input logic                      wvalid,
  input logic                      awready,
  input logic                      wready,
  input logic                      bvalid,
  input logic                      bready,
  input axil_regs_pkg::axil_resp_t bresp,
  input logic                      arready,
  input logic                      rvalid,
  input logic                      rready,
  input axil_regs_pkg::axil_data_t rdata,
  input axil_regs_pkg::axil_resp_t rresp
);
  import rst_seq_pkg::*;

  localparam int RELEASE_AGE = (1 << `RST_CNT_W) + 2;

  int fail_count = 0;
  int hold_age;  // Edges since lock was first sampled in wait_lock

  always_ff @(posedge sys_clk0) begin
    if (reset || soft_rst || !pll_lock) begin
      hold_age <= 0;
    end else if (seq_state == wait_lock) begin
      hold_age <= 1;
    end else if (hold_age < 1000) begin
      hold_age <= hold_age + 1;
    end
  end

  a_reset_values: assert property (@(posedge sys_clk0) $fell(reset) |->
      sys_rst && (&domain_rst) && !awready && !wready && !arready &&
      !bvalid && !rvalid && !soft_rst)
    else begin
      fail_count++;
      $error("Outputs not at reset values");
    end

  a_hold_early: assert property (@(posedge sys_clk0) disable iff (reset)
      (hold_age < RELEASE_AGE) |-> sys_rst)
    else begin
      fail_count++;
      $error("sys_rst released before the hold ended");
    end

  a_hold_exact: assert property (@(posedge sys_clk0) disable iff (reset)
      $fell(sys_rst) |-> (hold_age == RELEASE_AGE))
    else begin
      fail_count++;
      $error("sys_rst released at the wrong cycle");
    end

  a_aw_pulse: assert property (@(posedge sys_clk0) disable iff (reset)
      awready |=> !awready)
    else begin
      fail_count++;
      $error("awready held longer than one cycle");
    end

  // Accepted write gives bvalid on the next cycle, with wready in the accept cycle
  a_b_after_accept: assert property (@(posedge sys_clk0) disable iff (reset)
      (awready && awvalid && wvalid) |=> (bvalid && $past(wready)))
    else begin
      fail_count++;
      $error("Write accept without wready or without bvalid on the next cycle");
    end

  a_ar_block: assert property (@(posedge sys_clk0) disable iff (reset) arready |-> !rvalid)
    else begin
      fail_count++;
      $error("Read accepted while a response is held");
    end

  a_b_hold: assert property (@(posedge sys_clk0) disable iff (reset)
      (bvalid && !bready) |=> (bvalid && $stable(bresp)))
    else begin
      fail_count++;
      $error("Write response dropped before bready");
    end

  a_r_hold: assert property (@(posedge sys_clk0) disable iff (reset)
      (rvalid && !rready) |=> (rvalid && $stable(rdata) && $stable(rresp)))
    else begin
      fail_count++;
      $error("Read response dropped before rready");
    end

  // Release and assertion bounds in each user domain
  for (genvar i = 0; i < `NUM_DOMAINS; i++) begin : g_dom
    int low_age;
    int high_age;

    always_ff @(posedge user_clk[i]) begin
      low_age  <= sys_rst ? 0 : ((low_age < 100) ? low_age + 1 : low_age);
      high_age <= !sys_rst ? 0 : ((high_age < 100) ? high_age + 1 : high_age);
    end

    a_release: assert property (@(posedge user_clk[i]) disable iff (reset)
        (low_age > `SYNC_STAGES) |-> !domain_rst[i])
      else begin
        fail_count++;
        $error("Domain reset not released in time");
      end

    a_assert: assert property (@(posedge user_clk[i]) disable iff (reset)
        (high_age > `SYNC_STAGES) |-> domain_rst[i])
      else begin
        fail_count++;
        $error("Domain reset not asserted in time");
      end
  end

endmodule

bind clk_rst_infra clk_rst_infra_asserts u_asserts (
  .sys_clk0 (sys_clk0), .reset (reset), .pll_lock (pll_lock), .user_clk (user_clk),
  .sys_rst (sys_rst), .domain_rst (domain_rst), .soft_rst (soft_rst),
  .seq_state (u_seq.state),
  .awvalid (awvalid), .wvalid (wvalid),
  .awready (awready), .wready (wready), .bvalid (bvalid), .bready (bready),
  .bresp (bresp), .arready (arready), .rvalid (rvalid), .rready (rready),
  .rdata (rdata), .rresp (rresp)
);

// ==== dv/clk_rst_infra_tb.sv ====
`timescale 1ns/1ps
`include "clk_rst_cfg.svh"

module clk_rst_infra_tb;
  import rst_seq_pkg::*;
  import axil_regs_pkg::*;

  localparam int  HOLD_CYCLES  = (1 << `RST_CNT_W) + 1;
  localparam int  HOLD_PERIODS = 5;  // First lock, three glitches, soft reset
  localparam real WATCHDOG_NS  = HOLD_PERIODS * (HOLD_CYCLES + 200) * 20.0;

  logic        sys_clk0 = 1'b0;
  logic        reset    = 1'b1;
  logic        pll_lock = 1'b0;
  domain_vec_t uclk_gen = '0;
  domain_vec_t user_clk = '0;
  logic        sys_rst;
  domain_vec_t domain_rst;
  axil_addr_t  awaddr  = '0;
  logic        awvalid = 1'b0;
  logic        awready;
  axil_data_t  wdata   = '0;
  axil_strb_t  wstrb   = '0;
  logic        wvalid  = 1'b0;
  logic        wready;
  axil_resp_t  bresp;
  logic        bvalid;
  logic        bready  = 1'b0;
  axil_addr_t  araddr  = '0;
  logic        arvalid = 1'b0;
  logic        arready;
  axil_data_t  rdata;
  axil_resp_t  rresp;
  logic        rvalid;
  logic        rready  = 1'b0;
  int          loss_tally = 0;

  always #10 sys_clk0 = ~sys_clk0;

  // User clocks of 14, 26 and 34 ns
  always #7  uclk_gen[0] = ~uclk_gen[0];
  always #13 uclk_gen[1] = ~uclk_gen[1];
  always #17 uclk_gen[2] = ~uclk_gen[2];

  // Small phase shift keeps user edges off the sys_clk0 edges
  always @(uclk_gen) begin
    #0.5;
    user_clk = uclk_gen;
  end

  clk_rst_infra uut (
    .sys_clk0 (sys_clk0), .reset (reset), .pll_lock (pll_lock), .user_clk (user_clk),
    .sys_rst (sys_rst), .domain_rst (domain_rst),
    .awaddr (awaddr), .awvalid (awvalid), .awready (awready),
    .wdata (wdata), .wstrb (wstrb), .wvalid (wvalid), .wready (wready),
    .bresp (bresp), .bvalid (bvalid), .bready (bready),
    .araddr (araddr), .arvalid (arvalid), .arready (arready),
    .rdata (rdata), .rresp (rresp), .rvalid (rvalid), .rready (rready)
  );

  task automatic stop_with_failure();
    $display("tests failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
    stop_with_failure();
  endtask

  // Status word as the register map defines it, from the port view
  function automatic axil_data_t expected_status();
    axil_data_t word;
    word = '0;
    word[0] = pll_lock;
    word[1] = sys_rst;
    word[4 +: `NUM_DOMAINS] = ~domain_rst;
    return word;
  endfunction

  task automatic axi_write(input axil_addr_t addr, input axil_data_t data,
                           input axil_resp_t exp_resp);
    int delay;
    delay = $urandom_range(1, 3);  // bvalid always waits at least one cycle
    @(posedge sys_clk0);
    awaddr  <= addr;
    wdata   <= data;
    wstrb   <= '1;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    do @(negedge sys_clk0); while (!awready);
    @(posedge sys_clk0);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    repeat (delay) @(posedge sys_clk0);
    bready <= 1'b1;
    do @(negedge sys_clk0); while (!bvalid);
    assert (bresp == exp_resp) else report_mismatch("bresp", 32'(bresp), 32'(exp_resp));
    @(posedge sys_clk0);
    bready <= 1'b0;
  endtask

  task automatic axi_read(input axil_addr_t addr, input axil_data_t exp_data,
                          input axil_resp_t exp_resp, input int delay);
    @(posedge sys_clk0);
    araddr  <= addr;
    arvalid <= 1'b1;
    do @(negedge sys_clk0); while (!arready);
    @(posedge sys_clk0);
    arvalid <= 1'b0;
    repeat (delay) @(posedge sys_clk0);
    rready <= 1'b1;
    do @(negedge sys_clk0); while (!rvalid);
    assert (rdata == exp_data) else report_mismatch("rdata", rdata, exp_data);
    assert (rresp == exp_resp) else report_mismatch("rresp", 32'(rresp), 32'(exp_resp));
    @(posedge sys_clk0);
    rready <= 1'b0;
  endtask

  // Wait for full release, then let domain_ready settle
  task automatic check_released();
    do @(negedge sys_clk0); while (sys_rst || (domain_rst != '0));
    repeat (4) @(posedge sys_clk0);
    axi_read(REG_STATUS, expected_status(), RESP_OKAY, $urandom_range(0, 3));
    axi_read(REG_LOSS_CNT, axil_data_t'(loss_tally), RESP_OKAY, $urandom_range(0, 3));
  endtask

  task automatic lock_glitch();
    int len;
    len = $urandom_range(1, 5);
    @(posedge sys_clk0);
    pll_lock <= 1'b0;
    repeat (len) @(posedge sys_clk0);
    pll_lock <= 1'b1;
    loss_tally++;
  endtask

  initial begin
    void'($urandom(32150));
    repeat (16) @(posedge sys_clk0);
    reset <= 1'b0;
    repeat (20) @(posedge sys_clk0);  // Lock still low, reset must hold
    pll_lock <= 1'b1;
    check_released();

    lock_glitch();                     // Loss while running
    repeat (40) @(posedge sys_clk0);
    lock_glitch();                     // Loss in the middle of the hold
    check_released();
    lock_glitch();
    check_released();

    axi_write(REG_CONTROL, 32'h1, RESP_OKAY);  // Soft reset, no lock loss
    check_released();

    axi_read('hC, '0, RESP_SLVERR, $urandom_range(0, 3));
    axi_write(REG_STATUS, 32'hFFFF, RESP_SLVERR);
    axi_read('hE, '0, RESP_SLVERR, 8);

    repeat (4) @(posedge sys_clk0);
    if (uut.u_asserts.fail_count == 0) begin
      $display("all tests passed");
      $finish;
    end else begin
      stop_with_failure();
    end
  end

  always @(negedge sys_clk0) begin
    if (uut.u_asserts.fail_count != 0) begin
      $display("Assertion in the bound checker failed");
      stop_with_failure();
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before the test sequence finished");
    stop_with_failure();
  end

endmodule

// ==== sources.f ====
+incdir+include
rtl/rst_seq_pkg.sv
rtl/axil_regs_pkg.sv
rtl/reset_sequencer.sv
rtl/domain_rst_sync.sv
rtl/reset_status_regs.sv
rtl/clk_rst_infra.sv
dv/clk_rst_infra_asserts.sv
dv/clk_rst_infra_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
TOP       ?= clk_rst_infra_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
